//--- filelist.f
src/tunnel_pkg.sv
src/draw_sequencer.sv
src/shape_decode.sv
src/rect_fill.sv
src/frame_store.sv
src/tunnel_draw_top.sv
tests/tunnel_draw_asserts.sv
tests/tunnel_draw_tb.sv

//--- Makefile
# Verilator build and run of the tunnel renderer testbench

LOG := sim.log

.PHONY: sim clean

sim:
	verilator --binary --timing --assert -j 0 --timescale 1ns/100ps \
		--top-module tunnel_draw_tb -f filelist.f -Mdir obj_dir -o tunnel_draw_sim
	./obj_dir/tunnel_draw_sim +verilator+error+limit+100 | tee $(LOG)
	grep -q "All checks passed" $(LOG)

clean:
	rm -rf obj_dir $(LOG)

//--- tests/tunnel_draw_tb.sv
// --------------------------------------
// tunnel renderer testbench: frames,
// reference image and display readback
// --------------------------------------
`default_nettype none

module tunnel_draw_tb;
    timeunit 1ns;
    timeprecision 100ps;

    logic                         clk_pix = 1'b0;
    logic                         arst_n;
    logic                         frame_start;
    logic [tunnel_pkg::ADDRW-1:0] rd_addr;
    logic [tunnel_pkg::CIDXW-1:0] rd_cidx;
    logic                         busy;
    logic                         draw_done;

    // rectangle geometry per shape, outermost first
    int shape_x0   [tunnel_pkg::SHAPE_CNT] = '{4, 8, 10, 12, 13, 14, 15};
    int shape_y0   [tunnel_pkg::SHAPE_CNT] = '{0, 4, 6, 8, 9, 10, 11};
    int shape_x1   [tunnel_pkg::SHAPE_CNT] = '{27, 23, 21, 19, 18, 17, 16};
    int shape_y1   [tunnel_pkg::SHAPE_CNT] = '{23, 19, 17, 15, 14, 13, 12};
    int shape_grow [tunnel_pkg::SHAPE_CNT] = '{0, 1, 1, 1, 1, 1, 1};

    int frame_total    = 64;
    int timeout_cycles = 64 * 3000 + 100;
    int cycle_cnt      = 0;
    int frames_sent    = 0;
    int draw_count     = 0;
    logic [31:0] rng   = 32'd93952;

    logic rd_req = 1'b0;  // read address valid this cycle
    logic rd_chk = 1'b0;  // its data is on rd_cidx
    logic [tunnel_pkg::CIDXW-1:0] exp_q [$];
    logic             first_pix_armed = 1'b0;
    tunnel_pkg::pix_t first_pix_exp;

    tunnel_draw_top uut (
        .clk_pix, .arst_n, .frame_start, .rd_addr, .rd_cidx, .busy, .draw_done
    );

    bind tunnel_draw_top tunnel_draw_asserts u_asserts (.*);

    always #2 clk_pix = ~clk_pix;

    function automatic logic [31:0] xorshift32(input logic [31:0] s);
        logic [31:0] v;
        v = s;
        v = v ^ (v << 13);
        v = v ^ (v >> 17);
        v = v ^ (v << 5);
        return v;
    endfunction

    // animation state after frame_num frame_start pulses
    function automatic tunnel_pkg::anim_t anim_for_frame(input int frame_num);
        tunnel_pkg::anim_t a;
        int steps;
        int r;
        steps = frame_num / tunnel_pkg::ANIM_SPEED;
        r = steps % tunnel_pkg::ANIM_CNT;
        a.step = r[tunnel_pkg::STEPW-1:0];
        r = steps / tunnel_pkg::ANIM_CNT;
        a.colr_offs = r[tunnel_pkg::CIDXW-1:0];  // wraps modulo 16
        return a;
    endfunction

    function automatic logic [tunnel_pkg::CIDXW-1:0] expected_cidx(
        input int x, input int y, input int frame_num);
        tunnel_pkg::anim_t a;
        logic [tunnel_pkg::CIDXW-1:0] c;
        int s;
        int g;
        a = anim_for_frame(frame_num);
        c = a.colr_offs;  // background
        for (s = 0; s < tunnel_pkg::SHAPE_CNT; s++) begin
            g = shape_grow[s] * int'(a.step);
            if (x >= shape_x0[s] - g && x <= shape_x1[s] + g &&
                y >= shape_y0[s] - g && y <= shape_y1[s] + g) begin
                c = a.colr_offs + s[tunnel_pkg::CIDXW-1:0];  // later shape on top
            end
        end
        return c;
    endfunction

    task automatic fail_run();
        $display("Checks failed");
        $fatal(1);
    endtask

    task automatic check_cidx(input string name, input logic [tunnel_pkg::CIDXW-1:0] got,
                              input logic [tunnel_pkg::CIDXW-1:0] exp);
        if (got !== exp) begin
            $display("FAILED %s: got %h, expected %h", name, got, exp);
            fail_run();
        end
    endtask

    task automatic check_pix(input string name, input tunnel_pkg::pix_t got,
                             input tunnel_pkg::pix_t exp);
        if (got !== exp) begin
            $display("FAILED %s: got x=%h y=%h cidx=%h, expected x=%h y=%h cidx=%h",
                     name, got.x, got.y, got.cidx, exp.x, exp.y, exp.cidx);
            fail_run();
        end
    endtask

    task automatic check_flag(input string name, input logic got, input logic exp);
        if (got !== exp) begin
            $display("FAILED %s: got %h, expected %h", name, got, exp);
            fail_run();
        end
    endtask

    task automatic pulse_frame();
        tunnel_pkg::anim_t a;
        int g;
        int v;
        frame_start = 1'b1;
        frames_sent = frames_sent + 1;
        a = anim_for_frame(frames_sent);
        g = shape_grow[0] * int'(a.step);
        v = shape_x0[0] - g;
        first_pix_exp.x = v[tunnel_pkg::CORDW-1:0];
        v = shape_y0[0] - g;
        first_pix_exp.y = v[tunnel_pkg::CORDW-1:0];
        first_pix_exp.cidx = a.colr_offs;  // shape 0 adds nothing
        first_pix_armed = 1'b1;
        @(negedge clk_pix);
        frame_start = 1'b0;
    endtask

    task automatic wait_draw_done();
        while (!draw_done) begin
            check_flag("busy", busy, 1'b1);
            @(negedge clk_pix);
        end
        check_flag("busy", busy, 1'b0);
    endtask

    // display side of the buffer pair, one address per cycle
    task automatic read_back_frame(input int frame_num);
        int addr;
        for (addr = 0; addr < tunnel_pkg::FB_PIXELS; addr++) begin
            rd_addr = addr[tunnel_pkg::ADDRW-1:0];
            rd_req  = 1'b1;
            exp_q.push_back(expected_cidx(addr % tunnel_pkg::FB_WIDTH,
                                          addr / tunnel_pkg::FB_WIDTH, frame_num));
            check_flag("busy", busy, 1'b1);  // clear alone outlasts the readback
            @(negedge clk_pix);
        end
        rd_req = 1'b0;
    endtask

    always @(posedge clk_pix) begin
        rd_chk <= rd_req;
        cycle_cnt = cycle_cnt + 1;
        if (cycle_cnt > timeout_cycles) begin
            $display("Run timed out after %0d cycles without finishing", timeout_cycles);
            fail_run();
        end
    end

    // compare outputs where they are stable
    always @(negedge clk_pix) begin
        if (rd_chk) check_cidx("rd_cidx", rd_cidx, exp_q.pop_front());
        if (first_pix_armed && uut.pix_valid) begin
            first_pix_armed = 1'b0;
            check_pix("pix", uut.pix, first_pix_exp);
        end
        if (draw_done) draw_count = draw_count + 1;
        if (uut.u_asserts.fail_seen) begin
            $display("A bound assertion on the DUT failed");
            fail_run();
        end
    end

    initial begin
        int i;
        int n;
        logic [31:0] r32;
        arst_n      = 1'b0;
        frame_start = 1'b0;
        rd_addr     = '0;
        repeat (5) @(negedge clk_pix);
        arst_n = 1'b1;
        @(negedge clk_pix);
        check_flag("busy", busy, 1'b0);
        check_flag("draw_done", draw_done, 1'b0);

        // idle reads must not start anything
        for (i = 0; i < 16; i++) begin
            rng = xorshift32(rng);
            r32 = rng % tunnel_pkg::FB_PIXELS;
            rd_addr = r32[tunnel_pkg::ADDRW-1:0];
            @(negedge clk_pix);
            check_flag("draw_done", draw_done, 1'b0);
            check_flag("busy", busy, 1'b0);
        end

        pulse_frame();
        wait_draw_done();
        for (n = 1; n <= frame_total; n++) begin
            pulse_frame();  // frame n moves to the display side
            read_back_frame(n);
            wait_draw_done();
        end
        @(negedge clk_pix);

        if (draw_count != frames_sent) begin
            $display("FAILED draw_done count: got %h, expected %h", draw_count, frames_sent);
            fail_run();
        end else begin
            $display("All checks passed");
            $finish;
        end
    end

endmodule

`default_nettype wire

//--- tests/tunnel_draw_asserts.sv
// --------------------------------------
// bound checks on the tunnel renderer
// --------------------------------------
`default_nettype none

module tunnel_draw_asserts (
    input wire logic             clk_pix,
    input wire logic             arst_n,
    input wire logic             frame_start,
    input wire logic             busy,
    input wire logic             draw_done,
    input wire logic             clear_done,
    input wire tunnel_pkg::pix_t pix,
    input wire logic             pix_valid
);
    timeunit 1ns;
    timeprecision 100ps;

    // sticky, one per property
    logic draw_pulse_bad  = 1'b0;
    logic clear_pulse_bad = 1'b0;
    logic coord_bad       = 1'b0;
    logic reset_busy_bad  = 1'b0;
    logic start_busy_bad  = 1'b0;
    logic fail_seen;

    assign fail_seen = draw_pulse_bad | clear_pulse_bad | coord_bad
                     | reset_busy_bad | start_busy_bad;

    draw_done_pulse: assert property (@(posedge clk_pix) disable iff (!arst_n)
        draw_done |=> !draw_done)
        else begin
            draw_pulse_bad = 1'b1;
            $error("draw_done high for more than one cycle");
        end

    clear_done_pulse: assert property (@(posedge clk_pix) disable iff (!arst_n)
        clear_done |=> !clear_done)
        else begin
            clear_pulse_bad = 1'b1;
            $error("clear_done high for more than one cycle");
        end

    // the frame is as wide as the x coordinate range
    pix_in_frame: assert property (@(posedge clk_pix) disable iff (!arst_n)
        pix_valid |-> int'(pix.y) < tunnel_pkg::FB_HEIGHT)
        else begin
            coord_bad = 1'b1;
            $error("pixel outside the frame");
        end

    // async reset holds the FSM idle
    idle_in_reset: assert property (@(posedge clk_pix) !arst_n |-> !busy && !draw_done)
        else begin
            reset_busy_bad = 1'b1;
            $error("busy or draw_done high during reset");
        end

    start_when_idle: assert property (@(posedge clk_pix) disable iff (!arst_n)
        frame_start |-> !busy)
        else begin
            start_busy_bad = 1'b1;
            $error("frame_start while a frame is still drawn");
        end

endmodule

`default_nettype wire

//--- src/tunnel_draw_top.sv
// --------------------------------------
// tunnel renderer top level
// --------------------------------------
`default_nettype none

module tunnel_draw_top (
    input  wire logic                          clk_pix,
    input  wire logic                          arst_n,
    input  wire logic                          frame_start,
    input  wire logic [tunnel_pkg::ADDRW-1:0]  rd_addr,
    output logic [tunnel_pkg::CIDXW-1:0]       rd_cidx,
    output logic                               busy,
    output logic                               draw_done
);

    tunnel_pkg::anim_t            anim;
    logic [tunnel_pkg::SHAPEW-1:0] shape_id;
    logic                         shape_load;
    logic                         clear;
    logic [tunnel_pkg::CIDXW-1:0] clear_cidx;
    logic                         clear_done;
    logic                         buf_sel;
    tunnel_pkg::rect_cmd_t        rect_cmd;
    logic                         cmd_valid;
    tunnel_pkg::pix_t             pix;
    logic                         pix_valid;
    logic                         fill_done;

    draw_sequencer u_seq (
        .clk_pix, .arst_n, .frame_start, .clear_done, .fill_done,
        .anim, .shape_id, .shape_load, .clear, .clear_cidx,
        .buf_sel, .busy, .draw_done
    );

    shape_decode u_decode (
        .clk_pix, .arst_n, .shape_load, .shape_id, .anim,
        .rect_cmd, .cmd_valid
    );

    rect_fill u_fill (
        .clk_pix, .arst_n, .cmd_valid, .rect_cmd,
        .pix, .pix_valid, .fill_done
    );

    frame_store u_store (
        .clk_pix, .arst_n, .buf_sel, .clear, .clear_cidx, .clear_done,
        .pix, .pix_valid, .rd_addr, .rd_cidx
    );

endmodule

`default_nettype wire

//--- src/frame_store.sv
// --------------------------------------
// double frame buffer with clear engine,
// pixel address stage and read port
// --------------------------------------
`default_nettype none

module frame_store (
    input  wire logic                          clk_pix,
    input  wire logic                          arst_n,
    input  wire logic                          buf_sel,
    input  wire logic                          clear,
    input  wire logic [tunnel_pkg::CIDXW-1:0]  clear_cidx,
    output logic                               clear_done,
    input  wire tunnel_pkg::pix_t              pix,
    input  wire logic                          pix_valid,
    input  wire logic [tunnel_pkg::ADDRW-1:0]  rd_addr,
    output logic [tunnel_pkg::CIDXW-1:0]       rd_cidx
);

    logic [tunnel_pkg::CIDXW-1:0] fb0 [tunnel_pkg::FB_PIXELS];
    logic [tunnel_pkg::CIDXW-1:0] fb1 [tunnel_pkg::FB_PIXELS];

    // clear engine
    logic                         clr_active;
    logic [tunnel_pkg::ADDRW-1:0] clr_addr;
    logic [tunnel_pkg::CIDXW-1:0] clr_cidx;

    // registered draw write
    logic                         draw_we;
    logic [tunnel_pkg::ADDRW-1:0] draw_addr;
    logic [tunnel_pkg::CIDXW-1:0] draw_cidx;
    logic [tunnel_pkg::ADDRW-1:0] px_ext;
    logic [tunnel_pkg::ADDRW-1:0] py_ext;

    // merged write port
    logic                         we;
    logic [tunnel_pkg::ADDRW-1:0] waddr;
    logic [tunnel_pkg::CIDXW-1:0] wdata;

    always_ff @(posedge clk_pix or negedge arst_n) begin
        if (!arst_n) begin
            clr_active <= 1'b0;
            clr_addr   <= '0;
            clear_done <= 1'b0;
            draw_we    <= 1'b0;
        end else begin
            clear_done <= 1'b0;
            draw_we    <= pix_valid;
            if (clear) begin
                clr_active <= 1'b1;
                clr_addr   <= '0;
            end else if (clr_active) begin
                if (clr_addr == tunnel_pkg::ADDR_LAST) begin
                    clr_active <= 1'b0;
                    clear_done <= 1'b1;
                end else begin
                    clr_addr <= clr_addr + 1'b1;
                end
            end
        end
    end

    assign px_ext = {{(tunnel_pkg::ADDRW - tunnel_pkg::CORDW){1'b0}}, pix.x};
    assign py_ext = {{(tunnel_pkg::ADDRW - tunnel_pkg::CORDW){1'b0}}, pix.y};

    always_ff @(posedge clk_pix) begin
        if (clear) clr_cidx <= clear_cidx;
        draw_addr <= py_ext * tunnel_pkg::ROW_STRIDE + px_ext;  // y*width + x
        draw_cidx <= pix.cidx;
    end

    // clear and draw never overlap in time
    assign we    = clr_active | draw_we;
    assign waddr = clr_active ? clr_addr : draw_addr;
    assign wdata = clr_active ? clr_cidx : draw_cidx;

    always_ff @(posedge clk_pix) begin
        if (we && !buf_sel) fb0[waddr] <= wdata;
        if (we && buf_sel)  fb1[waddr] <= wdata;
        rd_cidx <= buf_sel ? fb0[rd_addr] : fb1[rd_addr];  // display side
    end

endmodule

`default_nettype wire

//--- src/rect_fill.sv
// --------------------------------------
// filled rectangle walker, raster order
// one pixel per cycle
// --------------------------------------
`default_nettype none

module rect_fill (
    input  wire logic                  clk_pix,
    input  wire logic                  arst_n,
    input  wire logic                  cmd_valid,
    input  wire tunnel_pkg::rect_cmd_t rect_cmd,
    output tunnel_pkg::pix_t           pix,
    output logic                       pix_valid,
    output logic                       fill_done
);

    // latched bounds for the row and line wrap
    logic [tunnel_pkg::CORDW-1:0] x0_q;
    logic [tunnel_pkg::CORDW-1:0] x1_q;
    logic [tunnel_pkg::CORDW-1:0] y1_q;

    logic last_col;
    logic last_row;

    assign last_col = (pix.x == x1_q);
    assign last_row = (pix.y == y1_q);

    always_ff @(posedge clk_pix or negedge arst_n) begin
        if (!arst_n) begin
            pix_valid <= 1'b0;
            fill_done <= 1'b0;
        end else begin
            fill_done <= 1'b0;
            if (cmd_valid) begin
                pix_valid <= 1'b1;
            end else if (pix_valid && last_col && last_row) begin
                pix_valid <= 1'b0;  // bottom right corner was just sent
                fill_done <= 1'b1;
            end
        end
    end

    // coordinates and colour carry no reset
    always_ff @(posedge clk_pix) begin
        if (cmd_valid) begin
            x0_q     <= rect_cmd.x0;
            x1_q     <= rect_cmd.x1;
            y1_q     <= rect_cmd.y1;
            pix.x    <= rect_cmd.x0;
            pix.y    <= rect_cmd.y0;
            pix.cidx <= rect_cmd.cidx;
        end else if (pix_valid) begin
            if (last_col) begin
                pix.x <= x0_q;  // next row
                if (!last_row) pix.y <= pix.y + 1'b1;
            end else begin
                pix.x <= pix.x + 1'b1;
            end
        end
    end

endmodule

`default_nettype wire

//--- src/shape_decode.sv
// --------------------------------------
// shape decode: table lookup plus grow
// and colour offset, registered command
// --------------------------------------
`default_nettype none

module shape_decode (
    input  wire logic                        clk_pix,
    input  wire logic                        arst_n,
    input  wire logic                        shape_load,
    input  wire logic [tunnel_pkg::SHAPEW-1:0] shape_id,
    input  wire tunnel_pkg::anim_t           anim,
    output tunnel_pkg::rect_cmd_t            rect_cmd,
    output logic                             cmd_valid
);

    tunnel_pkg::shape_geom_t      geom;
    logic [tunnel_pkg::CORDW-1:0] offs;      // pixels to grow each side
    tunnel_pkg::rect_cmd_t        cmd_next;

    always_comb begin
        geom = tunnel_pkg::SHAPE_TABLE[shape_id];

        // fixed shapes ignore the step
        if (geom.grow) begin
            offs = {{(tunnel_pkg::CORDW - tunnel_pkg::STEPW){1'b0}}, anim.step};
        end else begin
            offs = '0;
        end

        cmd_next.x0 = geom.x0 - offs;
        cmd_next.y0 = geom.y0 - offs;
        cmd_next.x1 = geom.x1 + offs;
        cmd_next.y1 = geom.y1 + offs;

        // colour wraps modulo 16
        cmd_next.cidx = anim.colr_offs
            + {{(tunnel_pkg::CIDXW - tunnel_pkg::SHAPEW){1'b0}}, shape_id};
    end

    always_ff @(posedge clk_pix or negedge arst_n) begin
        if (!arst_n) begin
            cmd_valid <= 1'b0;
        end else begin
            cmd_valid <= shape_load;
        end
    end

    always_ff @(posedge clk_pix) begin
        if (shape_load) rect_cmd <= cmd_next;
    end

endmodule

`default_nettype wire

//--- src/draw_sequencer.sv
// --------------------------------------
// draw sequencer: animation counters,
// buffer swap and clear/draw FSM
// --------------------------------------
`default_nettype none

module draw_sequencer (
    input  wire logic                            clk_pix,
    input  wire logic                            arst_n,
    input  wire logic                            frame_start,
    input  wire logic                            clear_done,
    input  wire logic                            fill_done,
    output tunnel_pkg::anim_t                    anim,
    output logic [tunnel_pkg::SHAPEW-1:0]        shape_id,
    output logic                                 shape_load,
    output logic                                 clear,
    output logic [tunnel_pkg::CIDXW-1:0]         clear_cidx,
    output logic                                 buf_sel,
    output logic                                 busy,
    output logic                                 draw_done
);

    typedef enum logic [1:0] {
        IDLE,
        CLEAR,
        LOAD,
        DRAW
    } state_t;

    state_t state;
    logic [tunnel_pkg::SPEEDW-1:0] speed_cnt;  // frames within current step

    // animation advances on every frame pulse
    always_ff @(posedge clk_pix or negedge arst_n) begin
        if (!arst_n) begin
            anim      <= '0;
            speed_cnt <= '0;
            buf_sel   <= 1'b0;
        end else if (frame_start) begin
            buf_sel <= ~buf_sel;  // swap draw and display buffers
            if (speed_cnt == tunnel_pkg::SPEED_LAST) begin
                speed_cnt <= '0;
                if (anim.step == tunnel_pkg::STEP_LAST) begin
                    anim.step      <= '0;
                    anim.colr_offs <= anim.colr_offs + 1'b1;
                end else begin
                    anim.step <= anim.step + 1'b1;
                end
            end else begin
                speed_cnt <= speed_cnt + 1'b1;
            end
        end
    end

    always_ff @(posedge clk_pix or negedge arst_n) begin
        if (!arst_n) begin
            state     <= IDLE;
            shape_id  <= '0;
            clear     <= 1'b0;
            draw_done <= 1'b0;
        end else begin
            clear     <= 1'b0;
            draw_done <= 1'b0;
            case (state)
                IDLE: if (frame_start) begin
                    state    <= CLEAR;
                    shape_id <= '0;
                    clear    <= 1'b1;
                end
                CLEAR: if (clear_done) state <= LOAD;
                LOAD: state <= DRAW;  // decoder registers the command
                DRAW: if (fill_done) begin
                    if (shape_id == tunnel_pkg::SHAPE_LAST) begin
                        state     <= IDLE;
                        draw_done <= 1'b1;
                    end else begin
                        shape_id <= shape_id + 1'b1;
                        state    <= LOAD;
                    end
                end
                default: state <= IDLE;
            endcase
        end
    end

    assign shape_load = (state == LOAD);
    assign busy       = (state != IDLE);
    assign clear_cidx = anim.colr_offs;  // already updated when clear fires

endmodule

`default_nettype wire

//--- src/tunnel_pkg.sv
// --------------------------------------
// tunnel renderer shared definitions
// frame geometry, animation and structs
// --------------------------------------
`default_nettype none

package tunnel_pkg;

    // frame buffer geometry
    localparam int FB_WIDTH  = 32;
    localparam int FB_HEIGHT = 24;
    localparam int FB_PIXELS = FB_WIDTH * FB_HEIGHT;  // 768

    localparam int CORDW = 5;   // coordinate width
    localparam int ADDRW = 10;  // buffer address width
    localparam int CIDXW = 4;   // colour index width

    // animation
    localparam int SHAPE_CNT  = 7;
    localparam int ANIM_CNT   = 5;  // steps per cycle of the tunnel
    localparam int ANIM_SPEED = 6;  // frames per step

    localparam int SHAPEW = 3;
    localparam int STEPW  = 3;
    localparam int SPEEDW = 3;

    // terminal counts, sized to their counters
    localparam logic [SHAPEW-1:0] SHAPE_LAST = SHAPEW'(SHAPE_CNT - 1);
    localparam logic [STEPW-1:0]  STEP_LAST  = STEPW'(ANIM_CNT - 1);
    localparam logic [SPEEDW-1:0] SPEED_LAST = SPEEDW'(ANIM_SPEED - 1);
    localparam logic [ADDRW-1:0]  ADDR_LAST  = ADDRW'(FB_PIXELS - 1);
    localparam logic [ADDRW-1:0]  ROW_STRIDE = ADDRW'(FB_WIDTH);

    typedef struct packed {
        logic [CORDW-1:0] x0;
        logic [CORDW-1:0] y0;
        logic [CORDW-1:0] x1;
        logic [CORDW-1:0] y1;
        logic             grow;  // grows by one pixel per step
    } shape_geom_t;

    // outermost shape first, later shapes paint over earlier ones
    localparam shape_geom_t SHAPE_TABLE [SHAPE_CNT] = '{
        '{5'd4,  5'd0,  5'd27, 5'd23, 1'b0},
        '{5'd8,  5'd4,  5'd23, 5'd19, 1'b1},
        '{5'd10, 5'd6,  5'd21, 5'd17, 1'b1},
        '{5'd12, 5'd8,  5'd19, 5'd15, 1'b1},
        '{5'd13, 5'd9,  5'd18, 5'd14, 1'b1},
        '{5'd14, 5'd10, 5'd17, 5'd13, 1'b1},
        '{5'd15, 5'd11, 5'd16, 5'd12, 1'b1}
    };

    typedef struct packed {
        logic [STEPW-1:0] step;       // 0 to ANIM_CNT-1
        logic [CIDXW-1:0] colr_offs;  // colour offset
    } anim_t;

    typedef struct packed {
        logic [CORDW-1:0] x0;
        logic [CORDW-1:0] y0;
        logic [CORDW-1:0] x1;
        logic [CORDW-1:0] y1;
        logic [CIDXW-1:0] cidx;
    } rect_cmd_t;

    typedef struct packed {
        logic [CORDW-1:0] x;
        logic [CORDW-1:0] y;
        logic [CIDXW-1:0] cidx;
    } pix_t;

endpackage

`default_nettype wire
